//--- logic/soc_cfg_pkg.sv
// soc_cfg_pkg: address map, bus widths and RAM depth of the on-chip memory subsystem
package soc_cfg_pkg;

   // bus widths
   localparam int ADDR_W = 32;             // byte address
   localparam int DATA_W = 128;            // one RAM line per beat
   localparam int STRB_W = DATA_W / 8;
   localparam int TAG_W  = 4;              // requester tag, source bit sits above it

   // RAM window, base 0 and 64 KB
   localparam logic [ADDR_W-1:0] RAM_BASE = 32'h0000_0000;
   localparam logic [ADDR_W-1:0] RAM_MASK = 32'h0000_ffff;

   // array geometry
   localparam int RAM_LINES   = 4096;      // 64 KB / 16 bytes
   localparam int LINE_OFFSET = 4;         // byte offset bits within a line

endpackage

//--- logic/mem_bus_pkg.sv
// mem_bus_pkg: request and response structs of the single-beat memory bus
package mem_bus_pkg;

   // tag on the shared side, src is 0 for cached memory and 1 for IO
   typedef struct packed {
      logic                          src;
      logic [soc_cfg_pkg::TAG_W-1:0] tag;
   } src_tag_t;

   // request after the combiner
   typedef struct packed {
      logic                           write;
      logic [soc_cfg_pkg::ADDR_W-1:0] addr;
      logic [soc_cfg_pkg::STRB_W-1:0] strb;   // byte enables, writes only
      logic [soc_cfg_pkg::DATA_W-1:0] data;
      src_tag_t                       tag;
   } mem_req_t;

   typedef struct packed {
      logic                           write;
      logic                           err;    // address outside the RAM window
      logic [soc_cfg_pkg::DATA_W-1:0] data;
      src_tag_t                       tag;
   } mem_rsp_t;

   // requester side, no source bit
   typedef struct packed {
      logic                           write;
      logic [soc_cfg_pkg::ADDR_W-1:0] addr;
      logic [soc_cfg_pkg::STRB_W-1:0] strb;
      logic [soc_cfg_pkg::DATA_W-1:0] data;
      logic [soc_cfg_pkg::TAG_W-1:0]  tag;
   } port_req_t;

   typedef struct packed {
      logic                           write;
      logic                           err;
      logic [soc_cfg_pkg::DATA_W-1:0] data;
      logic [soc_cfg_pkg::TAG_W-1:0]  tag;
   } port_rsp_t;

endpackage

//--- logic/pipe_reg.sv
`timescale 1ns/100ps
// pipe_reg: one-entry valid/ready register slice for an arbitrary payload
module pipe_reg #(
   parameter type payload_t = logic
) (
   input  logic     ram_clk,
   input  logic     rst_i,
   input  logic     in_valid_i,
   input  payload_t in_i,
   output logic     in_ready_o,
   output logic     out_valid_o,
   output payload_t out_o,
   input  logic     out_ready_i
);

   logic     valid_q;
   payload_t data_q;
   logic     load;

   // free slot, or the held item leaves this cycle
   assign in_ready_o = !valid_q || out_ready_i;
   assign load       = in_valid_i && in_ready_o;

   always_ff @(posedge ram_clk) begin
      if (rst_i) begin
         valid_q <= 1'b0;
      end else if (load) begin
         valid_q <= 1'b1;
      end else if (out_ready_i) begin
         valid_q <= 1'b0;
      end
   end

   always_ff @(posedge ram_clk) begin
      if (load) begin
         data_q <= in_i;
      end
   end

   assign out_valid_o = valid_q;
   assign out_o       = data_q;

   // a stalled item must be offered unchanged until taken
   a_hold_stable: assert property (
      @(posedge ram_clk) disable iff (rst_i)
      out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_o)
   ) else $error("CHECK FAILED: pipe_reg out_o changed while stalled, out_o=%h", out_o);

endmodule

//--- logic/mem_combiner.sv
`timescale 1ns/100ps
// mem_combiner: round-robin merge of the memory and IO requesters onto one bus
module mem_combiner (
   input  logic                   ram_clk,
   input  logic                   rst_i,
   // port 0, cached memory
   input  logic                   p0_req_valid_i,
   input  mem_bus_pkg::port_req_t p0_req_i,
   output logic                   p0_req_ready_o,
   output logic                   p0_rsp_valid_o,
   output mem_bus_pkg::port_rsp_t p0_rsp_o,
   input  logic                   p0_rsp_ready_i,
   // port 1, IO to memory
   input  logic                   p1_req_valid_i,
   input  mem_bus_pkg::port_req_t p1_req_i,
   output logic                   p1_req_ready_o,
   output logic                   p1_rsp_valid_o,
   output mem_bus_pkg::port_rsp_t p1_rsp_o,
   input  logic                   p1_rsp_ready_i,
   // merged side
   output logic                   m_req_valid_o,
   output mem_bus_pkg::mem_req_t  m_req_o,
   input  logic                   m_req_ready_i,
   input  logic                   m_rsp_valid_i,
   input  mem_bus_pkg::mem_rsp_t  m_rsp_i,
   output logic                   m_rsp_ready_o
);

   logic                   last_q;     // 1 when port 1 won the last transfer
   logic                   gnt0;
   logic                   gnt1;
   logic                   rsp_src;
   mem_bus_pkg::port_req_t sel_req;
   mem_bus_pkg::port_rsp_t rsp_port;

   // on a tie the port that did not win last time goes first
   assign gnt0 = p0_req_valid_i && (!p1_req_valid_i || last_q);
   assign gnt1 = p1_req_valid_i && (!p0_req_valid_i || !last_q);

   assign m_req_valid_o  = gnt0 || gnt1;
   assign p0_req_ready_o = gnt0 && m_req_ready_i;
   assign p1_req_ready_o = gnt1 && m_req_ready_i;

   always_comb begin
      sel_req         = gnt1 ? p1_req_i : p0_req_i;
      m_req_o.write   = sel_req.write;
      m_req_o.addr    = sel_req.addr;
      m_req_o.strb    = sel_req.strb;
      m_req_o.data    = sel_req.data;
      m_req_o.tag.src = gnt1;           // source bit above the tag
      m_req_o.tag.tag = sel_req.tag;
   end

   always_ff @(posedge ram_clk) begin
      if (rst_i) begin
         last_q <= 1'b1;                // port 0 first out of reset
      end else if (m_req_valid_o && m_req_ready_i) begin
         last_q <= gnt1;
      end
   end

   // responses go back by source bit
   assign rsp_src = m_rsp_i.tag.src;

   always_comb begin
      rsp_port.write = m_rsp_i.write;
      rsp_port.err   = m_rsp_i.err;
      rsp_port.data  = m_rsp_i.data;
      rsp_port.tag   = m_rsp_i.tag.tag;
   end

   assign p0_rsp_valid_o = m_rsp_valid_i && !rsp_src;
   assign p1_rsp_valid_o = m_rsp_valid_i && rsp_src;
   assign p0_rsp_o       = rsp_port;
   assign p1_rsp_o       = rsp_port;
   assign m_rsp_ready_o  = rsp_src ? p1_rsp_ready_i : p0_rsp_ready_i;

   a_one_grant: assert property (
      @(posedge ram_clk) disable iff (rst_i)
      !(gnt0 && gnt1)
   ) else $error("CHECK FAILED: mem_combiner gnt0=%h gnt1=%h", gnt0, gnt1);

endmodule

//--- logic/bram_ctrl.sv
`timescale 1ns/100ps
// bram_ctrl: on-chip RAM controller with window check, byte-strobed writes and one-cycle reads
module bram_ctrl #(
   parameter int LINES = soc_cfg_pkg::RAM_LINES
) (
   input  logic                  ram_clk,
   input  logic                  rst_i,
   input  logic                  req_valid_i,
   input  mem_bus_pkg::mem_req_t req_i,
   output logic                  req_ready_o,
   output logic                  rsp_valid_o,
   output mem_bus_pkg::mem_rsp_t rsp_o,
   input  logic                  rsp_ready_i
);

   localparam int IDX_W = $clog2(LINES);

   logic [soc_cfg_pkg::DATA_W-1:0] ram [0:LINES-1];
   logic [IDX_W-1:0]               line_idx;
   logic                           in_win;
   logic                           accept;
   logic                           ram_we;
   logic                           rsp_valid_q;
   mem_bus_pkg::mem_rsp_t          rsp_q;

   // only the window base/mask is decoded, no other target
   assign in_win   = (req_i.addr & ~soc_cfg_pkg::RAM_MASK) == soc_cfg_pkg::RAM_BASE;
   assign line_idx = req_i.addr[soc_cfg_pkg::LINE_OFFSET +: IDX_W];

   assign req_ready_o = !rsp_valid_q || rsp_ready_i;
   assign accept      = req_valid_i && req_ready_o;
   assign ram_we      = accept && in_win && req_i.write;

   // cleared array in place of a boot image
   initial begin
      for (int i = 0; i < LINES; i++) begin
         ram[i] = '0;
      end
   end

   always_ff @(posedge ram_clk) begin
      if (ram_we) begin
         for (int b = 0; b < soc_cfg_pkg::STRB_W; b++) begin
            if (req_i.strb[b]) begin
               ram[line_idx][b*8 +: 8] <= req_i.data[b*8 +: 8];
            end
         end
      end
   end

   always_ff @(posedge ram_clk) begin
      if (rst_i) begin
         rsp_valid_q <= 1'b0;
      end else if (accept) begin
         rsp_valid_q <= 1'b1;
      end else if (rsp_ready_i) begin
         rsp_valid_q <= 1'b0;
      end
   end

   // old line content, write of the same edge is not seen
   always_ff @(posedge ram_clk) begin
      if (accept) begin
         rsp_q.write <= req_i.write;
         rsp_q.err   <= !in_win;
         rsp_q.data  <= (in_win && !req_i.write) ? ram[line_idx] : '0;
         rsp_q.tag   <= req_i.tag;
      end
   end

   assign rsp_valid_o = rsp_valid_q;
   assign rsp_o       = rsp_q;

   // upstream stages must be empty while reset is held
   a_no_write_in_reset: assert property (
      @(posedge ram_clk) rst_i |-> !ram_we
   ) else $error("CHECK FAILED: bram_ctrl ram_we=%h during reset", ram_we);

endmodule

//--- logic/soc_mem_top.sv
`timescale 1ns/100ps
// soc_mem_top: two requesters sharing the on-chip RAM through combiner and register stages
module soc_mem_top (
   input  logic                   ram_clk,
   input  logic                   rst_i,
   input  logic                   p0_req_valid_i,
   input  logic                   p1_req_valid_i,
   input  mem_bus_pkg::port_req_t p0_req_i,
   input  mem_bus_pkg::port_req_t p1_req_i,
   output logic                   p0_req_ready_o,
   output logic                   p1_req_ready_o,
   output logic                   p0_rsp_valid_o,
   output logic                   p1_rsp_valid_o,
   output mem_bus_pkg::port_rsp_t p0_rsp_o,
   output mem_bus_pkg::port_rsp_t p1_rsp_o,
   input  logic                   p0_rsp_ready_i,
   input  logic                   p1_rsp_ready_i
);

   // combiner to request stage
   logic                  cb_req_valid;
   logic                  cb_req_ready;
   mem_bus_pkg::mem_req_t cb_req;
   // request stage to RAM
   logic                  ram_req_valid;
   logic                  ram_req_ready;
   mem_bus_pkg::mem_req_t ram_req;
   // RAM to response stage
   logic                  ram_rsp_valid;
   logic                  ram_rsp_ready;
   mem_bus_pkg::mem_rsp_t ram_rsp;
   // response stage back to combiner
   logic                  cb_rsp_valid;
   logic                  cb_rsp_ready;
   mem_bus_pkg::mem_rsp_t cb_rsp;

   mem_combiner u_combiner (
      .ram_clk        (ram_clk),
      .rst_i          (rst_i),
      .p0_req_valid_i (p0_req_valid_i),
      .p0_req_i       (p0_req_i),
      .p0_req_ready_o (p0_req_ready_o),
      .p0_rsp_valid_o (p0_rsp_valid_o),
      .p0_rsp_o       (p0_rsp_o),
      .p0_rsp_ready_i (p0_rsp_ready_i),
      .p1_req_valid_i (p1_req_valid_i),
      .p1_req_i       (p1_req_i),
      .p1_req_ready_o (p1_req_ready_o),
      .p1_rsp_valid_o (p1_rsp_valid_o),
      .p1_rsp_o       (p1_rsp_o),
      .p1_rsp_ready_i (p1_rsp_ready_i),
      .m_req_valid_o  (cb_req_valid),
      .m_req_o        (cb_req),
      .m_req_ready_i  (cb_req_ready),
      .m_rsp_valid_i  (cb_rsp_valid),
      .m_rsp_i        (cb_rsp),
      .m_rsp_ready_o  (cb_rsp_ready)
   );

   pipe_reg #(.payload_t(mem_bus_pkg::mem_req_t)) u_req_reg (
      .ram_clk     (ram_clk),
      .rst_i       (rst_i),
      .in_valid_i  (cb_req_valid),
      .in_i        (cb_req),
      .in_ready_o  (cb_req_ready),
      .out_valid_o (ram_req_valid),
      .out_o       (ram_req),
      .out_ready_i (ram_req_ready)
   );

   bram_ctrl #(.LINES(soc_cfg_pkg::RAM_LINES)) u_bram (
      .ram_clk     (ram_clk),
      .rst_i       (rst_i),
      .req_valid_i (ram_req_valid),
      .req_i       (ram_req),
      .req_ready_o (ram_req_ready),
      .rsp_valid_o (ram_rsp_valid),
      .rsp_o       (ram_rsp),
      .rsp_ready_i (ram_rsp_ready)
   );

   pipe_reg #(.payload_t(mem_bus_pkg::mem_rsp_t)) u_rsp_reg (
      .ram_clk     (ram_clk),
      .rst_i       (rst_i),
      .in_valid_i  (ram_rsp_valid),
      .in_i        (ram_rsp),
      .in_ready_o  (ram_rsp_ready),
      .out_valid_o (cb_rsp_valid),
      .out_o       (cb_rsp),
      .out_ready_i (cb_rsp_ready)
   );

endmodule

//--- testbench/tb_clkgen.sv
`timescale 1ns/100ps
// tb_clkgen: 10 ns RAM clock and synchronous reset held for a fixed number of cycles
module tb_clkgen #(
   parameter int RESET_CYCLES = 16
) (
   output logic ram_clk_o,
   output logic rst_o
);

   initial begin
      ram_clk_o = 1'b0;
      forever #5 ram_clk_o = ~ram_clk_o;
   end

   initial begin
      rst_o = 1'b1;
      repeat (RESET_CYCLES) @(posedge ram_clk_o);
      #1 rst_o = 1'b0;   // released with the stimulus, after the edge
   end

endmodule

//--- testbench/tb_soc_mem.sv
`timescale 1ns/100ps
// tb_soc_mem: directed and random traffic on both ports, checked against a byte model
module tb_soc_mem;

   typedef logic [soc_cfg_pkg::DATA_W-1:0] word_t;

   localparam int RESET_CYCLES   = 16;
   localparam int N_DIRECTED     = 16;                 // upper bound of the directed requests
   localparam int N_RAND         = 150;                // per port and per random phase
   localparam int TOTAL_REQ      = N_DIRECTED + 4 * N_RAND;
   localparam int TIMEOUT_CYCLES = 2 * TOTAL_REQ * 8 + RESET_CYCLES;
   localparam int WIN_BYTES      = int'(soc_cfg_pkg::RAM_MASK) + 1;

   logic                   ram_clk;
   logic                   rst_i;
   logic [1:0]             req_valid;
   logic [1:0]             req_ready;
   mem_bus_pkg::port_req_t req_pl [2];
   logic [1:0]             rsp_valid;
   logic [1:0]             rsp_ready = 2'b11;
   mem_bus_pkg::port_rsp_t rsp_pl [2];

   logic [7:0]             model_mem [0:WIN_BYTES-1];
   mem_bus_pkg::port_rsp_t exp_q0 [$];
   mem_bus_pkg::port_rsp_t exp_q1 [$];
   int                     n_accepted = 0;
   int                     cycles = 0;
   logic                   rand_ready = 1'b0;    // random response back-pressure on
   logic [31:0]            ready_rnd;

   tb_clkgen #(.RESET_CYCLES(RESET_CYCLES)) u_clkgen (
      .ram_clk_o (ram_clk),
      .rst_o     (rst_i)
   );

   soc_mem_top u_dut (
      .ram_clk        (ram_clk),
      .rst_i          (rst_i),
      .p0_req_valid_i (req_valid[0]),
      .p1_req_valid_i (req_valid[1]),
      .p0_req_i       (req_pl[0]),
      .p1_req_i       (req_pl[1]),
      .p0_req_ready_o (req_ready[0]),
      .p1_req_ready_o (req_ready[1]),
      .p0_rsp_valid_o (rsp_valid[0]),
      .p1_rsp_valid_o (rsp_valid[1]),
      .p0_rsp_o       (rsp_pl[0]),
      .p1_rsp_o       (rsp_pl[1]),
      .p0_rsp_ready_i (rsp_ready[0]),
      .p1_rsp_ready_i (rsp_ready[1])
   );

   task automatic stop_on_error(input string msg);
      $display("%s", msg);
      $display("Finished with errors");
      $fatal(1, "run stopped at first error");
   endtask

   task automatic report_mismatch(input string name, input word_t got, input word_t exp);
      stop_on_error($sformatf("CHECK FAILED: %s got=%h exp=%h", name, got, exp));
   endtask

   // expected response by the window rule, model updated in acceptance order
   function automatic mem_bus_pkg::port_rsp_t model_access(input mem_bus_pkg::port_req_t req);
      mem_bus_pkg::port_rsp_t     rsp;
      logic [soc_cfg_pkg::ADDR_W-1:0] offset;
      int                         line_base;
      offset        = req.addr - soc_cfg_pkg::RAM_BASE;
      rsp.write     = req.write;
      rsp.tag       = req.tag;
      rsp.data      = '0;
      rsp.err       = offset > soc_cfg_pkg::RAM_MASK;   // wraps below the base too
      line_base     = int'(offset) & ~(soc_cfg_pkg::STRB_W - 1);
      if (!rsp.err) begin
         for (int b = 0; b < soc_cfg_pkg::STRB_W; b++) begin
            if (req.write && req.strb[b]) begin
               model_mem[line_base + b] = req.data[b*8 +: 8];
            end else if (!req.write) begin
               rsp.data[b*8 +: 8] = model_mem[line_base + b];
            end
         end
      end
      return rsp;
   endfunction

   function automatic word_t rand_word();
      return {$urandom(), $urandom(), $urandom(), $urandom()};
   endfunction

   task automatic check_rsp(input int port, input mem_bus_pkg::port_rsp_t got);
      mem_bus_pkg::port_rsp_t exp;
      string                  name;
      name = $sformatf("p%0d_rsp_o", port);
      if (port == 0) begin
         assert (exp_q0.size() > 0)
            else stop_on_error("port 0 returned a response with no request outstanding");
         exp = exp_q0.pop_front();
      end else begin
         assert (exp_q1.size() > 0)
            else stop_on_error("port 1 returned a response with no request outstanding");
         exp = exp_q1.pop_front();
      end
      assert (got.tag == exp.tag)
         else report_mismatch({name, ".tag"}, word_t'(got.tag), word_t'(exp.tag));
      assert (got.write == exp.write)
         else report_mismatch({name, ".write"}, word_t'(got.write), word_t'(exp.write));
      assert (got.err == exp.err)
         else report_mismatch({name, ".err"}, word_t'(got.err), word_t'(exp.err));
      assert (got.data == exp.data)
         else report_mismatch({name, ".data"}, got.data, exp.data);
   endtask

   // compare process, sampled mid-cycle where every handshake signal is settled
   always @(negedge ram_clk) begin
      if (!rst_i) begin
         if (n_accepted == 0) begin
            assert (rsp_valid == 2'b00)
               else report_mismatch("rsp_valid_o", word_t'(rsp_valid), '0);
         end
         for (int p = 0; p < 2; p++) begin
            if (req_valid[p] && req_ready[p]) begin
               n_accepted++;
               if (p == 0) exp_q0.push_back(model_access(req_pl[0]));
               else exp_q1.push_back(model_access(req_pl[1]));
            end
            if (rsp_valid[p] && rsp_ready[p]) begin
               check_rsp(p, rsp_pl[p]);
            end
         end
      end
   end

   always @(posedge ram_clk) begin
      cycles <= cycles + 1;
      if (cycles >= TIMEOUT_CYCLES) begin
         stop_on_error("timeout, the cycle limit was reached before all responses came back");
      end
   end

   always @(posedge ram_clk) begin
      #1;
      ready_rnd = $urandom();
      rsp_ready = rand_ready ? ready_rnd[1:0] : 2'b11;
   end

   task automatic wait_cycles(input int n);
      repeat (n) begin
         @(posedge ram_clk);
         #1;
      end
   endtask

   // hold valid and payload until the transfer edge
   task automatic send_req(input int port, input mem_bus_pkg::port_req_t req);
      req_pl[port]    = req;
      req_valid[port] = 1'b1;
      @(negedge ram_clk);
      while (!req_ready[port]) @(negedge ram_clk);
      @(posedge ram_clk);
      #1;
      req_valid[port] = 1'b0;
   endtask

   task automatic wait_drained();
      while (exp_q0.size() != 0 || exp_q1.size() != 0) @(posedge ram_clk);
      #1;
   endtask

   task automatic single_req(input int port, input logic write,
                             input logic [soc_cfg_pkg::ADDR_W-1:0] addr,
                             input logic [soc_cfg_pkg::STRB_W-1:0] strb,
                             input word_t data, input logic [soc_cfg_pkg::TAG_W-1:0] tag);
      mem_bus_pkg::port_req_t req;
      req.write = write;
      req.addr  = addr;
      req.strb  = strb;
      req.data  = data;
      req.tag   = tag;
      send_req(port, req);
      wait_drained();
   endtask

   task automatic random_traffic(input int port, input int count);
      mem_bus_pkg::port_req_t req;
      logic [31:0]            rnd;
      logic [31:0]            hi;
      for (int i = 0; i < count; i++) begin
         rnd   = $urandom();
         hi    = $urandom();
         req.write = rnd[0];
         req.strb  = rnd[31:16];
         req.data  = rand_word();
         req.tag   = i[3:0];   // running tag exposes reordering
         // 32 hot lines at both ends of the window, some misses outside it
         req.addr  = {(rnd[15:13] == 3'b000) ? {hi[31:17], 1'b1} : 16'h0000,
                      rnd[12] ? 8'hff : 8'h00, rnd[11:8], hi[3:0]};
         send_req(port, req);
         wait_cycles($urandom_range(0, 3));
      end
   endtask

   initial begin
      void'($urandom(59));
      req_valid = 2'b00;
      req_pl[0] = '0;
      req_pl[1] = '0;
      for (int a = 0; a < WIN_BYTES; a++) begin
         model_mem[a] = 8'h00;
      end
      @(negedge rst_i);
      wait_cycles(4);   // idle, no response may show up

      // write then read back on each port
      single_req(0, 1'b1, 32'h0000_0100, 16'hffff, rand_word(), 4'h3);
      single_req(0, 1'b0, 32'h0000_0100, 16'h0000, '0, 4'h4);
      single_req(1, 1'b1, 32'h0000_0110, 16'hffff, rand_word(), 4'h9);
      single_req(1, 1'b0, 32'h0000_0110, 16'h0000, '0, 4'ha);

      // partial strobes over a full line
      single_req(0, 1'b1, 32'h0000_0200, 16'hffff, rand_word(), 4'h1);
      single_req(1, 1'b1, 32'h0000_0200, 16'h00f0, rand_word(), 4'h2);
      single_req(1, 1'b1, 32'h0000_0204, 16'h8001, rand_word(), 4'h3);
      single_req(0, 1'b0, 32'h0000_0200, 16'h0000, '0, 4'h5);
      single_req(1, 1'b0, 32'h0000_0200, 16'h0000, '0, 4'h6);

      // outside the window, then the aliased line
      single_req(0, 1'b1, 32'h0001_0100, 16'hffff, rand_word(), 4'h7);
      single_req(1, 1'b0, 32'h0001_0100, 16'h0000, '0, 4'h8);
      single_req(0, 1'b0, 32'h0000_0100, 16'h0000, '0, 4'h9);
      single_req(1, 1'b0, 32'hffff_fff0, 16'h0000, '0, 4'hb);

      fork
         random_traffic(0, N_RAND);
         random_traffic(1, N_RAND);
      join
      rand_ready = 1'b1;
      fork
         random_traffic(0, N_RAND);
         random_traffic(1, N_RAND);
      join
      wait_drained();
      rand_ready = 1'b0;
      wait_cycles(2);

      if (exp_q0.size() == 0 && exp_q1.size() == 0) begin
         $display("Finished with no errors");
         $finish;
      end else begin
         stop_on_error("expected responses were still outstanding at the end of the run");
      end
   end

endmodule

//--- all.f
logic/soc_cfg_pkg.sv
logic/mem_bus_pkg.sv
logic/pipe_reg.sv
logic/mem_combiner.sv
logic/bram_ctrl.sv
logic/soc_mem_top.sv
testbench/tb_clkgen.sv
testbench/tb_soc_mem.sv

//--- Makefile
# Verilator build and run of the on-chip memory testbench

SIM_TOOL  = verilator
SIM_FLAGS = --binary --timing --assert -j 0
TOP       = tb_soc_mem
FILE_LIST = all.f
BUILD_DIR = obj_dir
LOG       = sim.log
FAIL_MSG  = Finished with errors
PASS_MSG  = Finished with no errors

.PHONY: sim clean

sim:
	$(SIM_TOOL) $(SIM_FLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG) || ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation failed"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
